/* Bender.yml */
package:
  name: uart_can_bridge

sources:
  - hdl/uart_pkg.sv
  - hdl/can_pkg.sv
  - hdl/uart_rx.sv
  - hdl/payload_packer.sv
  - hdl/can_crc15.sv
  - hdl/can_frame_tx.sv
  - hdl/uart_can_bridge.sv
  - target: simulation
    files:
      - sim/bridge_checker.sv
      - sim/tb_top.sv

/* compile.f */
hdl/uart_pkg.sv
hdl/can_pkg.sv
hdl/uart_rx.sv
hdl/payload_packer.sv
hdl/can_crc15.sv
hdl/can_frame_tx.sv
hdl/uart_can_bridge.sv
sim/bridge_checker.sv
sim/tb_top.sv

/* hdl/can_crc15.sv */
module can_crc15 (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           crc_clear,
    input  logic                           crc_shift,
    input  logic                           crc_bit,
    output logic [can_pkg::can_crc_bits-1:0] crc
);
    import can_pkg::*;

    logic feedback;   // Incoming bit against the register MSB

    assign feedback = crc_bit ^ crc[can_crc_bits-1];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            crc <= '0;
        end else if (crc_clear) begin
            crc <= '0;                          // Start value for every frame
        end else if (crc_shift) begin
            if (feedback) begin
                crc <= {crc[can_crc_bits-2:0], 1'b0} ^ can_crc_poly;
            end else begin
                crc <= {crc[can_crc_bits-2:0], 1'b0};
            end
        end
    end

endmodule

/* hdl/can_frame_tx.sv */
module can_frame_tx #(
    parameter logic [can_pkg::can_id_bits-1:0] frame_id = 11'h20D
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 can_tick,
    input  can_pkg::can_payload_t payload,
    input  logic                 frame_load,
    output logic                 tx_busy,
    output logic                 can_out
);
    import can_pkg::*;

    localparam int dlc_bits  = 4;
    localparam int hdr_bits  = 1 + can_id_bits + 3 + dlc_bits + 8 * can_payload_bytes;
    localparam int crc_end   = hdr_bits + can_crc_bits;   // First bit after the CRC field
    localparam int cnt_bits  = $clog2(can_frame_bits + 1);
    localparam int crc_sel_w = $clog2(can_crc_bits);

    localparam logic [cnt_bits-1:0] hdr_len   = cnt_bits'(hdr_bits);
    localparam logic [cnt_bits-1:0] crc_len   = cnt_bits'(crc_end);
    localparam logic [cnt_bits-1:0] crc_last  = cnt_bits'(crc_end - 1);
    localparam logic [cnt_bits-1:0] frame_len = cnt_bits'(can_frame_bits);

    logic [hdr_bits-1:0]     shift_reg;     // SOF through last data bit
    logic [cnt_bits-1:0]     bit_cnt;       // Bits already presented
    logic [can_crc_bits-1:0] crc;
    logic [crc_sel_w-1:0]    crc_sel;       // CRC bit for the current position
    logic                    frame_start;
    logic                    tick_active;   // Tick that presents a frame bit
    logic                    in_header;
    logic                    in_crc;
    logic                    next_bit;

    assign frame_start = frame_load && !tx_busy;
    assign tick_active = tx_busy && can_tick && (bit_cnt != frame_len);
    assign in_header   = bit_cnt < hdr_len;
    assign in_crc      = !in_header && (bit_cnt < crc_len);
    assign crc_sel     = crc_sel_w'(crc_last - bit_cnt);

    // Delimiters, ACK slot and EOF are all recessive
    always_comb begin
        if (in_header) begin
            next_bit = shift_reg[hdr_bits-1];
        end else if (in_crc) begin
            next_bit = crc[crc_sel];
        end else begin
            next_bit = 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            tx_busy <= 1'b0;
            can_out <= 1'b1;
            bit_cnt <= '0;
        end else if (frame_start) begin
            tx_busy <= 1'b1;
            bit_cnt <= '0;
        end else if (tx_busy && can_tick) begin
            if (bit_cnt == frame_len) begin
                tx_busy <= 1'b0;                // Frame complete, bus back to idle
                can_out <= 1'b1;
            end else begin
                can_out <= next_bit;
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // SOF dominant, RTR IDE r0 dominant for a base data frame
    always_ff @(posedge clock) begin
        if (frame_start) begin
            shift_reg <= {1'b0, frame_id, 3'b000, dlc_bits'(can_dlc), payload.word};
        end else if (tick_active && in_header) begin
            shift_reg <= {shift_reg[hdr_bits-2:0], 1'b0};
        end
    end

    can_crc15 u_crc (
        .clock     (clock),
        .reset     (reset),
        .crc_clear (frame_start),
        .crc_shift (tick_active && in_header),
        .crc_bit   (shift_reg[hdr_bits-1]),
        .crc       (crc)
    );

    // Bus is recessive whenever no frame is in flight
    assert property (@(posedge clock) disable iff (reset) !tx_busy |-> can_out);

endmodule

/* hdl/can_pkg.sv */
package can_pkg;

    localparam int can_id_bits       = 11;     // Base format identifier
    localparam int can_dlc           = 8;      // Data length code sent in control field
    localparam int can_payload_bytes = 8;      // Bytes per frame payload
    localparam int can_eof_bits      = 7;      // Recessive end-of-frame bits
    localparam int can_crc_bits      = 15;     // CRC field width

    // CAN generator x^15+x^14+x^10+x^8+x^7+x^4+x^3+1
    localparam logic [can_crc_bits-1:0] can_crc_poly = 15'h4599;

    // SOF, id, RTR/IDE/r0, DLC, data, CRC, CRC delim, ACK slot, ACK delim, EOF
    localparam int can_frame_bits = 1 + can_id_bits + 3 + 4
                                  + 8 * can_payload_bytes
                                  + can_crc_bits + 3 + can_eof_bits;

    // One 64-bit payload word, filled bytewise and shifted out as a whole
    typedef union packed {
        logic [0:can_payload_bytes-1][7:0] bytes;  // Byte 0 sits in the top bits
        logic [8*can_payload_bytes-1:0]    word;   // Flat view, MSB leaves first
    } can_payload_t;

endpackage

/* hdl/payload_packer.sv */
module payload_packer (
    input  logic                 clock,
    input  logic                 reset,
    input  logic [7:0]           rx_byte,
    input  logic                 rx_valid,
    input  logic                 tx_busy,
    output can_pkg::can_payload_t payload,
    output logic                 frame_load,
    output logic                 overrun
);
    import can_pkg::*;

    localparam int idx_bits = $clog2(can_payload_bytes);
    localparam logic [idx_bits-1:0] last_idx = idx_bits'(can_payload_bytes - 1);

    logic [idx_bits-1:0] byte_idx;       // Slot for the next byte
    logic                payload_done;   // Last byte of a payload arrives

    assign payload_done = rx_valid && (byte_idx == last_idx);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            byte_idx   <= '0;
            frame_load <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            frame_load <= payload_done && !tx_busy;
            if (payload_done && tx_busy) begin
                overrun <= 1'b1;                // Sticky until reset
            end
            if (rx_valid) begin
                if (payload_done) begin
                    byte_idx <= '0;             // Next byte opens a new payload
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                end
            end
        end
    end

    // First byte lands in slot 0, the first data byte on the bus
    always_ff @(posedge clock) begin
        if (rx_valid) begin
            payload.bytes[byte_idx] <= rx_byte;
        end
    end

    // The transmitter must never be offered a frame while it is sending one
    assert property (@(posedge clock) disable iff (reset) frame_load |-> !tx_busy);

endmodule

/* hdl/uart_can_bridge.sv */
module uart_can_bridge #(
    parameter logic [can_pkg::can_id_bits-1:0] frame_id = 11'h20D
) (
    input  logic clock,
    input  logic reset,
    input  logic serial_in,
    input  logic uart_tick,
    input  logic can_tick,
    output logic can_out,
    output logic tx_busy,
    output logic overrun
);
    import can_pkg::*;

    logic [7:0]   rx_byte;
    logic         rx_valid;
    can_payload_t payload;
    logic         frame_load;

    uart_rx u_uart_rx (
        .clock     (clock),
        .reset     (reset),
        .uart_tick (uart_tick),
        .serial_in (serial_in),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid)
    );

    payload_packer u_packer (
        .clock      (clock),
        .reset      (reset),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .tx_busy    (tx_busy),
        .payload    (payload),
        .frame_load (frame_load),
        .overrun    (overrun)
    );

    can_frame_tx #(
        .frame_id (frame_id)
    ) u_can_tx (
        .clock      (clock),
        .reset      (reset),
        .can_tick   (can_tick),
        .payload    (payload),
        .frame_load (frame_load),
        .tx_busy    (tx_busy),
        .can_out    (can_out)
    );

endmodule

/* hdl/uart_pkg.sv */
package uart_pkg;

    // Character format is 1 start bit, data bits LSB first, 1 stop bit
    localparam int uart_data_bits = 8;   // Data bits per character

endpackage

/* hdl/uart_rx.sv */
module uart_rx (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               uart_tick,
    input  logic                               serial_in,
    output logic [uart_pkg::uart_data_bits-1:0] rx_byte,
    output logic                               rx_valid
);
    import uart_pkg::*;

    localparam int cnt_bits = $clog2(uart_data_bits);
    localparam logic [cnt_bits-1:0] last_bit = cnt_bits'(uart_data_bits - 1);

    localparam logic [1:0] rx_idle  = 2'd0;
    localparam logic [1:0] rx_start = 2'd1;
    localparam logic [1:0] rx_data  = 2'd2;
    localparam logic [1:0] rx_stop  = 2'd3;

    logic [1:0]                state;
    logic [cnt_bits-1:0]       bit_cnt;     // Data bit position
    logic [uart_data_bits-1:0] shift_reg;   // Assembles the character
    logic                      serial_q;    // Previous line level for edge detect

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= rx_idle;
            bit_cnt  <= '0;
            serial_q <= 1'b1;
            rx_valid <= 1'b0;
        end else begin
            serial_q <= serial_in;
            rx_valid <= 1'b0;
            case (state)
                rx_idle: begin
                    if (serial_q && !serial_in) begin   // Falling edge opens a character
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    if (uart_tick) begin
                        if (serial_in) begin
                            state <= rx_idle;           // Glitch, not a start bit
                        end else begin
                            state   <= rx_data;
                            bit_cnt <= '0;
                        end
                    end
                end
                rx_data: begin
                    if (uart_tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == last_bit) begin
                            state <= rx_stop;
                        end
                    end
                end
                rx_stop: begin
                    if (uart_tick) begin
                        state    <= rx_idle;
                        rx_valid <= serial_in;          // Framing error drops the byte
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == rx_data && uart_tick) begin
            shift_reg <= {serial_in, shift_reg[uart_data_bits-1:1]};  // LSB arrives first
        end
        if (state == rx_stop && uart_tick && serial_in) begin
            rx_byte <= shift_reg;
        end
    end

    // A byte strobe is a single cycle; a new one needs a whole character time
    assert property (@(posedge clock) disable iff (reset) rx_valid |=> !rx_valid);

endmodule

/* sim/bridge_checker.sv */
module bridge_checker #(
    parameter logic [can_pkg::can_id_bits-1:0] frame_id = 11'h20D
) (
    input logic clock,
    input logic reset,
    input logic can_tick,
    input logic tx_busy,
    input logic can_out,
    input logic overrun
);
    timeunit 1ns;
    timeprecision 100ps;

    import can_pkg::*;

    int value_errors = 0;
    int other_errors = 0;
    int frames_seen  = 0;

    logic [63:0]                payload_q[$];     // Frames still to appear on the bus
    logic [can_crc_bits-1:0]    crc_q[$];
    logic                       ovr_watch = 1'b0; // Compare overrun every cycle
    logic                       ovr_exp = 1'b0;
    logic                       tick_q;
    logic                       reset_q;
    logic [can_frame_bits-1:0]  rx_frame;         // Bits rebuilt from can_out
    int                         bit_idx;

    // Remainder of M(x) * x^15 divided by the CAN generator, by long division
    function automatic logic [14:0] crc15_of(input logic [82:0] bits);
        logic [97:0] rem;
        rem = {bits, 15'b0};
        for (int i = 97; i >= 15; i--) begin
            if (rem[i]) begin
                rem[i -: 16] = rem[i -: 16] ^ 16'hC599;
            end
        end
        return rem[14:0];
    endfunction

    function automatic logic [82:0] header_bits(input logic [63:0] payload);
        return {1'b0, frame_id, 3'b000, 4'd8, payload};   // SOF, id, RTR IDE r0, DLC, data
    endfunction

    task automatic expect_frame(input logic [63:0] payload, input logic [14:0] crc);
        logic [14:0] own_crc;
        own_crc = crc15_of(header_bits(payload));
        if (own_crc !== crc) begin
            value_errors++;
            $display("ERR %0t crc_file expected %h actual %h", $time, own_crc, crc);
        end
        payload_q.push_back(payload);
        crc_q.push_back(crc);
    endtask

    task automatic watch_overrun(input logic enable, input logic value);
        ovr_watch = enable;
        ovr_exp   = value;
    endtask

    task automatic report_field(input string name, input logic [63:0] exp_val,
                                input logic [63:0] act_val);
        if (exp_val !== act_val) begin
            value_errors++;
            $display("ERR %0t can_out.%s expected %h actual %h", $time, name, exp_val, act_val);
        end
    endtask

    task automatic compare_frame();
        logic [can_frame_bits-1:0] exp_frame;
        if (payload_q.size() == 0) begin
            other_errors++;
            $display("A frame was transmitted although no payload was pending at %0t", $time);
            return;
        end
        frames_seen++;
        exp_frame = {header_bits(payload_q.pop_front()), crc_q.pop_front(), 10'h3FF};
        report_field("sof",     64'(exp_frame[107]),      64'(rx_frame[107]));
        report_field("id",      64'(exp_frame[106:96]),   64'(rx_frame[106:96]));
        report_field("control", 64'(exp_frame[95:89]),    64'(rx_frame[95:89]));
        report_field("data",    exp_frame[88:25],         rx_frame[88:25]);
        report_field("crc",     64'(exp_frame[24:10]),    64'(rx_frame[24:10]));
        report_field("tail",    64'(exp_frame[9:0]),      64'(rx_frame[9:0]));
    endtask

    task automatic report_leftover();
        if (payload_q.size() != 0) begin
            other_errors++;
            $display("%0d expected frames were never transmitted", payload_q.size());
        end
        if (tx_busy !== 1'b0 || bit_idx != 0) begin
            other_errors++;
            $display("A frame was still being transmitted when the run ended");
        end
        if (frames_seen == 0) begin
            other_errors++;
            $display("No frame was received and checked during the run");
        end
    endtask

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            tick_q  = 1'b0;
            reset_q = 1'b1;
            bit_idx = 0;
        end else begin
            if (reset_q && tx_busy !== 1'b0) begin
                value_errors++;
                $display("ERR %0t tx_busy expected 0 actual %b", $time, tx_busy);
            end
            if (reset_q && overrun !== 1'b0) begin
                value_errors++;
                $display("ERR %0t overrun expected 0 actual %b", $time, overrun);
            end
            if (!tx_busy && can_out !== 1'b1) begin
                value_errors++;
                $display("ERR %0t can_out expected 1 actual %b", $time, can_out);
            end
            if (ovr_watch && overrun !== ovr_exp) begin
                value_errors++;
                $display("ERR %0t overrun expected %b actual %b", $time, ovr_exp, overrun);
            end
            if (!tx_busy && bit_idx != 0) begin
                other_errors++;
                $display("Frame ended after only %0d bits at %0t", bit_idx, $time);
                bit_idx = 0;
            end
            if (tick_q && tx_busy) begin                 // Bit presented after last tick
                rx_frame[can_frame_bits-1-bit_idx] = can_out;
                bit_idx++;
                if (bit_idx == can_frame_bits) begin
                    compare_frame();
                    bit_idx = 0;
                end
            end
            tick_q  = can_tick && tx_busy;
            reset_q = 1'b0;
        end
    end

endmodule

/* sim/bridge_stimulus.txt */
// First word is the record count; each record is one line of eleven hex words
// mode (0 normal, 1 slow bus, 2 dropped), byte0..byte7, bad stop position (8 none), crc
0004
// Plain frame
0000 0012 0034 0056 0078 009A 00BC 00DE 00F0 0008 3964
// Bad stop character ahead of byte 3
0000 0012 0034 0056 0078 009A 00BC 00DE 00F0 0003 3964
// Slow bus frame, sent in full
0001 0012 0034 0056 0078 009A 00BC 00DE 00F0 0008 3964
// Arrives while the slow frame is busy, never sent
0002 0055 00AA 0011 0022 0033 0044 0066 0077 0008 0000

/* sim/tb_top.sv */
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [10:0] frame_id = 11'h20D;

    logic        clock;
    logic        reset;
    logic        serial_in;
    logic        uart_tick;
    logic        can_tick;
    logic        can_out;
    logic        tx_busy;
    logic        overrun;
    logic        slow_can;         // Overrun test runs the bus slowly
    logic [2:0]  uart_div;
    logic [5:0]  can_div;
    logic [15:0] stim_mem [0:63];
    int          limit_cycles = 0;

    uart_can_bridge #(
        .frame_id (frame_id)
    ) dut0 (
        .clock     (clock),
        .reset     (reset),
        .serial_in (serial_in),
        .uart_tick (uart_tick),
        .can_tick  (can_tick),
        .can_out   (can_out),
        .tx_busy   (tx_busy),
        .overrun   (overrun)
    );

    bridge_checker #(
        .frame_id (frame_id)
    ) chk0 (
        .clock    (clock),
        .reset    (reset),
        .can_tick (can_tick),
        .tx_busy  (tx_busy),
        .can_out  (can_out),
        .overrun  (overrun)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        uart_div  <= uart_div + 1'b1;
        can_div   <= can_div + 1'b1;
        uart_tick <= (uart_div == 3'd7);                          // Every 8 cycles
        can_tick  <= slow_can ? (can_div == 6'd63) : (can_div[1:0] == 2'd3);
    end

    task automatic wait_tick();
        @(posedge clock);
        while (uart_tick !== 1'b1) begin
            @(posedge clock);
        end
    endtask

    // Start, eight data bits LSB first, stop; each bit changes on a tick edge
    task automatic send_char(input logic [7:0] data, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, data, 1'b0};
        wait_tick();
        for (int i = 0; i < 10; i++) begin
            serial_in <= bits[i];
            wait_tick();
        end
        serial_in <= 1'b1;
    endtask

    task automatic idle_gap();
        int n;
        n = $urandom_range(20, 0);
        repeat (n) wait_tick();
    endtask

    task automatic send_payload(input logic [63:0] payload, input int bad_pos);
        for (int i = 0; i < 8; i++) begin
            if (i == bad_pos) begin
                send_char(8'($urandom_range(255, 0)), 1'b0);   // Framing error
                idle_gap();
            end
            send_char(payload[63-8*i -: 8], 1'b1);
            idle_gap();
        end
    endtask

    initial begin
        int unsigned seed_value;
        int          rec_count;
        int          base;
        int          bad_pos;
        logic [63:0] payload;
        logic [15:0] mode;
        seed_value = $urandom(32'h9f23);
        clock     = 1'b0;
        reset     = 1'b1;
        serial_in = 1'b1;
        uart_tick = 1'b0;
        can_tick  = 1'b0;
        slow_can  = 1'b0;
        uart_div  = '0;
        can_div   = '0;
        $readmemh("sim/bridge_stimulus.txt", stim_mem);
        rec_count    = stim_mem[0];
        limit_cycles = (rec_count + 2) * 108 * 64;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        chk0.watch_overrun(1'b1, 1'b0);
        for (int r = 0; r < rec_count; r++) begin
            base    = 1 + r * 11;                 // Mode, eight bytes, bad position, CRC
            mode    = stim_mem[base];
            bad_pos = stim_mem[base+9];
            for (int i = 0; i < 8; i++) begin
                payload[63-8*i -: 8] = stim_mem[base+1+i][7:0];
            end
            if (mode == 16'd2) begin
                chk0.watch_overrun(1'b0, 1'b0);   // Flag rises somewhere in this payload
            end else begin
                if (mode == 16'd1) begin
                    slow_can <= 1'b1;
                end
                chk0.expect_frame(payload, stim_mem[base+10][14:0]);
            end
            send_payload(payload, bad_pos);
            if (mode == 16'd2) begin
                wait (tx_busy == 1'b0);
                repeat (200) @(posedge clock);    // Dropped payload must not start a frame
                chk0.watch_overrun(1'b1, 1'b1);
                slow_can <= 1'b0;
            end else if (mode == 16'd0) begin
                wait (tx_busy == 1'b1);
                wait (tx_busy == 1'b0);
                repeat (50) @(posedge clock);
            end
        end
        repeat (20) @(posedge clock);
        chk0.report_leftover();
        $display("Errors: %0d wrong values, %0d other failures",
                 chk0.value_errors, chk0.other_errors);
        if (chk0.value_errors == 0 && chk0.other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clock);
        $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
